// File: build.f
design/cu_setup_pkg.sv
design/descriptor_capture.sv
design/setup_sequencer.sv
design/serial_read_engine.sv
design/request_fifo.sv
design/cu_setup_top.sv
testbench/cu_setup_asserts.sv
testbench/cu_setup_tb.sv

// File: design/cu_setup_pkg.sv
// Shared widths, constants and bus types of the compute-unit setup block
`default_nettype none

package cu_setup_pkg;

    // ----------------------------------------
    // Widths and constants
    // ----------------------------------------
    localparam int DATA_W       = 512;
    localparam int BEAT_SHIFT   = $clog2(DATA_W / 8);
    localparam int SETUP_WORD_W = 64;
    localparam int COUNT_W      = 32;
    localparam int ADDR_W       = 40;

    // Setup word layout
    localparam int FLUSH_EN_BIT = 2;
    localparam int PROG_LSB     = 3;

    // Request FIFO sizing
    localparam int FIFO_DEPTH   = 32;
    localparam int PROG_THRESH  = 16;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

    // ----------------------------------------
    // Bus types
    // ----------------------------------------
    typedef struct packed {
        logic                    valid;
        logic [SETUP_WORD_W-1:0] setup_word;
    } kernel_descriptor_t;

    typedef struct packed {
        logic [COUNT_W-1:0] count;
        logic               flush;
    } read_job_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              flush;
    } mem_request_payload_t;

    typedef struct packed {
        logic                 valid;
        mem_request_payload_t payload;
    } mem_request_t;

    // Phase machine of the sequencer
    typedef enum logic [3:0] {
        CU_SETUP_RESET,
        CU_SETUP_IDLE,
        CU_SETUP_PROG_START,
        CU_SETUP_PROG_BUSY,
        CU_SETUP_PROG_PAUSE,
        CU_SETUP_PROG_DONE,
        CU_SETUP_FLUSH_START,
        CU_SETUP_FLUSH_BUSY,
        CU_SETUP_FLUSH_PAUSE,
        CU_SETUP_FLUSH_DONE
    } setup_state_t;

endpackage

`default_nettype wire

// File: design/cu_setup_top.sv
// Compute-unit setup top level chaining capture, sequencer, read engine and FIFO
`default_nettype none

module cu_setup_top
    import cu_setup_pkg::*;
(
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  kernel_descriptor_t descriptor_in,
    input  logic               cu_flush,
    input  logic               request_ready,
    input  logic               response_valid,
    output mem_request_t       request_out,
    output logic               done_out
);

    // ----------------------------------------
    // Inter-stage signals
    // ----------------------------------------
    logic         descriptor_valid;
    logic         flush_enable;
    read_job_t    program_job;
    read_job_t    flush_job;
    logic         flush_request;
    logic         start;
    read_job_t    job;
    logic         engine_busy;
    mem_request_t push;
    logic         fifo_prog_full;
    logic         fifo_empty;

    descriptor_capture i_descriptor_capture (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_in    (descriptor_in),
        .cu_flush         (cu_flush),
        .descriptor_valid (descriptor_valid),
        .flush_enable     (flush_enable),
        .program_job      (program_job),
        .flush_job        (flush_job),
        .flush_request    (flush_request)
    );

    setup_sequencer i_setup_sequencer (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .flush_enable     (flush_enable),
        .program_job      (program_job),
        .flush_job        (flush_job),
        .flush_request    (flush_request),
        .engine_busy      (engine_busy),
        .fifo_empty       (fifo_empty),
        .fifo_prog_full   (fifo_prog_full),
        .response_valid   (response_valid),
        .start            (start),
        .job              (job),
        .done_out         (done_out)
    );

    serial_read_engine i_serial_read_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .start           (start),
        .job             (job),
        .prog_full       (fifo_prog_full),
        .push            (push),
        .busy            (engine_busy)
    );

    request_fifo i_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (push),
        .request_ready   (request_ready),
        .request_out     (request_out),
        .prog_full       (fifo_prog_full),
        .empty           (fifo_empty)
    );

endmodule

`default_nettype wire

// File: design/descriptor_capture.sv
// Descriptor capture that registers the kernel descriptor and decodes its read jobs
`default_nettype none

module descriptor_capture
    import cu_setup_pkg::*;
(
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  kernel_descriptor_t descriptor_in,
    input  logic               cu_flush,
    output logic               descriptor_valid,
    output logic               flush_enable,
    output read_job_t          program_job,
    output read_job_t          flush_job,
    output logic               flush_request
);

    logic [SETUP_WORD_W-1:0] setup_word_reg;

    // Valid and flush level
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            descriptor_valid <= 1'b0;
            flush_request    <= 1'b0;
        end else begin
            descriptor_valid <= descriptor_in.valid;
            flush_request    <= cu_flush;
        end
    end

    always_ff @(posedge ap_clk) begin
        setup_word_reg <= descriptor_in.setup_word;
    end

    // ----------------------------------------
    // Setup word decode
    // ----------------------------------------
    assign flush_enable = setup_word_reg[FLUSH_EN_BIT];

    // Program count sits above the flag bits of the low half
    assign program_job.count = COUNT_W'(setup_word_reg[COUNT_W-1:PROG_LSB]);
    assign program_job.flush = 1'b0;

    // Flush count takes the whole upper half
    assign flush_job.count = setup_word_reg[SETUP_WORD_W-1:COUNT_W];
    assign flush_job.flush = 1'b1;

endmodule

`default_nettype wire

// File: design/request_fifo.sv
// Request FIFO with programmable-full flag and a registered output stage
`default_nettype none

module request_fifo
    import cu_setup_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_cu_setup,
    input  mem_request_t push,
    input  logic         request_ready,
    output mem_request_t request_out,
    output logic         prog_full,
    output logic         empty
);

    mem_request_payload_t  mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   occupancy;
    logic                  ready_reg;
    logic                  pop;
    logic                  out_valid;
    mem_request_payload_t  out_payload;

    assign empty     = (occupancy == '0);
    assign prog_full = (occupancy >= (FIFO_PTR_W + 1)'(PROG_THRESH));

    // Ready is sampled a cycle early
    assign pop = ~empty & ready_reg;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.payload;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            ready_reg <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            ready_reg <= request_ready;
            out_valid <= pop;
            if (push.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push.valid, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Output stage
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            out_payload <= mem[rd_ptr];
        end
    end

    assign request_out.valid   = out_valid;
    assign request_out.payload = out_payload;

endmodule

`default_nettype wire

// File: design/serial_read_engine.sv
// Serial read engine that steps a read job into one addressed request per beat
`default_nettype none

module serial_read_engine
    import cu_setup_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_cu_setup,
    input  logic         start,
    input  read_job_t    job,
    input  logic         prog_full,
    output mem_request_t push,
    output logic         busy
);

    logic [COUNT_W-1:0] beat_index;
    logic [COUNT_W-1:0] next_index;
    logic               active;
    logic               issue;

    // Hold off while the FIFO is above its threshold
    assign issue      = active & ~prog_full;
    assign next_index = beat_index + COUNT_W'(1);

    // ----------------------------------------
    // Beat stepping
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            active     <= 1'b0;
            beat_index <= '0;
        end else if (start) begin
            // Empty job never goes active
            active     <= (job.count != '0);
            beat_index <= '0;
        end else if (issue) begin
            beat_index <= next_index;
            if (next_index == job.count) begin
                active <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Request out
    // ----------------------------------------
    assign push.valid         = issue;
    assign push.payload.addr  = ADDR_W'(beat_index) << BEAT_SHIFT;
    assign push.payload.flush = job.flush;

    assign busy = active;

endmodule

`default_nettype wire

// File: design/setup_sequencer.sv
// Setup sequencer that runs the program and flush phases and signals completion
`default_nettype none

module setup_sequencer
    import cu_setup_pkg::*;
(
    input  logic      ap_clk,
    input  logic      areset_cu_setup,
    input  logic      descriptor_valid,
    input  logic      flush_enable,
    input  read_job_t program_job,
    input  read_job_t flush_job,
    input  logic      flush_request,
    input  logic      engine_busy,
    input  logic      fifo_empty,
    input  logic      fifo_prog_full,
    input  logic      response_valid,
    output logic      start,
    output read_job_t job,
    output logic      done_out
);

    setup_state_t       state;
    setup_state_t       next_state;
    logic [COUNT_W-1:0] response_count;
    logic               response_zero;
    logic               phase_complete;

    assign response_zero = (response_count == '0);

    // Engine drained, nothing queued, every beat answered
    assign phase_complete = ~engine_busy & fifo_empty & response_zero;

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= CU_SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CU_SETUP_RESET: begin
                next_state = CU_SETUP_IDLE;
            end
            CU_SETUP_IDLE: begin
                if (descriptor_valid) begin
                    next_state = CU_SETUP_PROG_START;
                end
            end
            CU_SETUP_PROG_START: begin
                next_state = CU_SETUP_PROG_BUSY;
            end
            CU_SETUP_PROG_BUSY: begin
                if (phase_complete) begin
                    next_state = CU_SETUP_PROG_DONE;
                end else if (fifo_prog_full) begin
                    next_state = CU_SETUP_PROG_PAUSE;
                end
            end
            CU_SETUP_PROG_PAUSE: begin
                if (~fifo_prog_full) begin
                    next_state = CU_SETUP_PROG_BUSY;
                end
            end
            CU_SETUP_PROG_DONE: begin
                // Flush waits for the external flush level
                if (~flush_enable) begin
                    next_state = CU_SETUP_FLUSH_DONE;
                end else if (flush_request) begin
                    next_state = CU_SETUP_FLUSH_START;
                end
            end
            CU_SETUP_FLUSH_START: begin
                next_state = CU_SETUP_FLUSH_BUSY;
            end
            CU_SETUP_FLUSH_BUSY: begin
                if (phase_complete) begin
                    next_state = CU_SETUP_FLUSH_DONE;
                end else if (fifo_prog_full) begin
                    next_state = CU_SETUP_FLUSH_PAUSE;
                end
            end
            CU_SETUP_FLUSH_PAUSE: begin
                if (~fifo_prog_full) begin
                    next_state = CU_SETUP_FLUSH_BUSY;
                end
            end
            CU_SETUP_FLUSH_DONE: begin
                next_state = CU_SETUP_FLUSH_DONE;
            end
            default: begin
                next_state = CU_SETUP_RESET;
            end
        endcase
    end

    // ----------------------------------------
    // Registered outputs
    // ----------------------------------------
    // Start pulses for the single cycle spent in a start state
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            start    <= 1'b0;
            done_out <= 1'b0;
        end else begin
            start    <= (next_state == CU_SETUP_PROG_START) |
                        (next_state == CU_SETUP_FLUSH_START);
            done_out <= (next_state == CU_SETUP_FLUSH_DONE);
        end
    end

    // Job is loaded on entry and then held for the phase
    always_ff @(posedge ap_clk) begin
        if (next_state == CU_SETUP_PROG_START) begin
            job <= program_job;
        end else if (next_state == CU_SETUP_FLUSH_START) begin
            job <= flush_job;
        end
    end

    // ----------------------------------------
    // Response counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            response_count <= '0;
        end else if (start) begin
            response_count <= job.count;
        end else if (response_valid & ~response_zero) begin
            response_count <= response_count - COUNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cu_setup_tb -f build.f \
    && ./obj_dir/Vcu_setup_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/cu_setup_asserts.sv
// Bound checks on the setup block outputs for reset, completion and address alignment
`default_nettype none

module cu_setup_asserts
    import cu_setup_pkg::*;
(
    input logic         ap_clk,
    input logic         areset_cu_setup,
    input mem_request_t request_out,
    input logic         done_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // Output stage is cleared one cycle into reset
    reset_quiet: assert property (@(posedge ap_clk)
        areset_cu_setup && $past(areset_cu_setup) |-> !request_out.valid)
        else $error("request_out.valid high during reset");

    // Done is sticky until the next reset
    done_sticky: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        done_out |=> done_out)
        else $error("done_out fell without reset");

    beat_aligned: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        request_out.valid |-> request_out.payload.addr[BEAT_SHIFT-1:0] == '0)
        else $error("request address not aligned to a beat");

endmodule

bind cu_setup_top cu_setup_asserts i_cu_setup_asserts (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .request_out     (request_out),
    .done_out        (done_out)
);

`default_nettype wire

// File: testbench/cu_setup_tb.sv
// Table-driven testbench for the compute-unit setup block with response model and watchdog
`default_nettype none

module cu_setup_tb
    import cu_setup_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS = 5;

    // Table row with setup word, cycles until cu_flush and a long ready stall flag
    typedef struct packed {
        logic [63:0] setup_word;
        logic [7:0]  flush_delay;
        logic        stall;
    } test_row_t;

    localparam test_row_t TEST_TABLE [NUM_ROWS] = '{
        '{64'h0000_0007_0000_0028, 8'd0,  1'b0},
        '{64'h0000_0004_0000_001C, 8'd60, 1'b0},
        '{64'h0000_0014_0000_0144, 8'd10, 1'b1},
        '{64'h0000_0009_0000_0000, 8'd0,  1'b0},
        '{64'h0000_0002_0000_0004, 8'd5,  1'b0}
    };

    logic               ap_clk;
    logic               areset_cu_setup;
    kernel_descriptor_t descriptor_in;
    logic               cu_flush;
    logic               request_ready = 1'b0;
    logic               response_valid = 1'b0;
    mem_request_t       request_out;
    logic               done_out;

    logic [15:0] lfsr_state = 16'd62595;
    int unsigned exp_prog;
    int unsigned exp_flush;
    int unsigned exp_total;
    logic        stall_mode;
    int unsigned req_count;
    int unsigned resp_count;
    int unsigned pending;
    int unsigned cycle_count;
    int unsigned beat;
    logic        flush_expected;

    cu_setup_top i_cu_setup_top (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_in   (descriptor_in),
        .cu_flush        (cu_flush),
        .request_ready   (request_ready),
        .response_valid  (response_valid),
        .request_out     (request_out),
        .done_out        (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic next_random_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // Request scoreboard and response model
    // ----------------------------------------
    always @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            req_count = 0;
            resp_count = 0;
            pending = 0;
            cycle_count = 0;
            request_ready <= 1'b0;
            response_valid <= 1'b0;
        end else begin
            cycle_count = cycle_count + 1;
            if (request_out.valid) begin
                if (req_count >= exp_total) begin
                    check_value("request_out.valid", 1, 0);
                end
                // Program beats first, then flush beats restarting at zero
                flush_expected = (req_count >= exp_prog);
                beat = flush_expected ? req_count - exp_prog : req_count;
                check_value("request_out.payload.addr", request_out.payload.addr, beat * 64);
                check_value("request_out.payload.flush", request_out.payload.flush,
                            flush_expected);
                if (flush_expected) begin
                    check_value("cu_flush", cu_flush, 1);
                end
                req_count = req_count + 1;
                pending = pending + 1;
            end
            if (done_out) begin
                check_value("response count at done_out", resp_count, exp_total);
            end
            if (stall_mode) begin
                request_ready <= cycle_count[6] & next_random_bit();
            end else begin
                request_ready <= next_random_bit() | next_random_bit();
            end
            if (pending != 0 && (next_random_bit() & next_random_bit())) begin
                response_valid <= 1'b1;
                pending = pending - 1;
                resp_count = resp_count + 1;
            end else begin
                response_valid <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Row sequencing
    // ----------------------------------------
    task automatic run_row(input test_row_t row);
        @(posedge ap_clk);
        areset_cu_setup <= 1'b1;
        descriptor_in <= '0;
        cu_flush <= 1'b0;
        @(posedge ap_clk);
        exp_prog = row.setup_word[31:3];
        exp_flush = row.setup_word[63:32];
        exp_total = exp_prog + (row.setup_word[2] ? exp_flush : 0);
        stall_mode = row.stall;
        repeat (RESET_CYCLES - 1) @(posedge ap_clk);
        areset_cu_setup <= 1'b0;
        descriptor_in <= '{valid: 1'b1, setup_word: row.setup_word};
        fork
            begin
                repeat (row.flush_delay) @(posedge ap_clk);
                cu_flush <= 1'b1;
            end
            begin
                while (done_out !== 1'b1) @(posedge ap_clk);
            end
        join
        // Let any stray request show up before the totals are checked
        repeat (40) @(posedge ap_clk);
        check_value("request count", req_count, exp_total);
        check_value("response count", resp_count, exp_total);
        check_value("done_out", done_out, 1);
    endtask

    initial begin
        areset_cu_setup = 1'b1;
        descriptor_in = '0;
        cu_flush = 1'b0;
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(TEST_TABLE[row]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Budget of 40 cycles per beat on top of reset and flush delays
    initial begin : watchdog
        int unsigned budget;
        budget = 0;
        for (int row = 0; row < NUM_ROWS; row++) begin
            budget += (TEST_TABLE[row].setup_word[31:3] + TEST_TABLE[row].setup_word[63:32]) * 40;
            budget += TEST_TABLE[row].flush_delay + 200;
        end
        repeat (budget) @(posedge ap_clk);
        $display("Timeout: done_out did not rise within %0d cycles", budget);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
